/* src/llc_cfg_pkg.sv */
// --------------------------------------------------
// cache geometry and victim lfsr constants
// num_ways should be a power of two, since the lfsr
// start index wraps in way_idx_len bits
// --------------------------------------------------
package llc_cfg_pkg;

  // associativity
  localparam int unsigned num_ways = 4;

  // lines per way, one tag entry each
  localparam int unsigned num_lines = 64;

  // line index width follows the line count
  localparam int unsigned index_len = $clog2(num_lines);

  // upper address bits kept per line
  localparam int unsigned tag_len = 10;

  // bits needed to name one way
  localparam int unsigned way_idx_len = $clog2(num_ways);

  // victim selection lfsr, x^8 + x^6 + x^5 + x^4 + 1
  localparam int unsigned lfsr_len = 8;
  localparam logic [lfsr_len-1:0] lfsr_taps = 8'hb8;
  // any non zero seed works
  localparam logic [lfsr_len-1:0] lfsr_seed = 8'h5a;

endpackage

/* src/llc_tag_pkg.sv */
// --------------------------------------------------
// types of the tag store interface
// widths come from llc_cfg_pkg
// tag_entry_t is the word held per line and way
// --------------------------------------------------
package llc_tag_pkg;

  // one bit per way, one-hot or multi-hot
  typedef logic [llc_cfg_pkg::num_ways-1:0] way_ind_t;

  // line index, also the memory address
  typedef logic [llc_cfg_pkg::index_len-1:0] index_t;

  // request kinds
  typedef enum logic [1:0] {
    BIST,
    FLUSH,
    LOOKUP,
    STORE
  } tag_req_e;

  // stored word, 12 bits
  typedef struct packed {
    logic                             valid;
    logic                             dirty;
    logic [llc_cfg_pkg::tag_len-1:0]  tag;
  } tag_entry_t;

  // request payload, 23 bits
  // way_ind is the target for STORE and FLUSH, unused otherwise
  typedef struct packed {
    tag_req_e                         mode;
    way_ind_t                         way_ind;
    index_t                           index;
    logic                             dirty;
    logic [llc_cfg_pkg::tag_len-1:0]  tag;
  } tag_req_t;

  // result payload, 17 bits
  // on a miss way_ind is the victim and tag/dirty describe the old line
  typedef struct packed {
    way_ind_t                         way_ind;
    logic                             hit;
    logic                             evict;
    logic [llc_cfg_pkg::tag_len-1:0]  tag;
    logic                             dirty;
  } tag_res_t;

endpackage

/* src/llc_tag_ram.sv */
// --------------------------------------------------
// behavioral single port memory, one cycle read
// read data holds until the next read
// a write does not update the read data
// --------------------------------------------------
module llc_tag_ram #(
  parameter type         payload_t = logic,
  parameter int unsigned num_words = llc_cfg_pkg::num_lines
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  llc_tag_pkg::index_t addr_i,
  input  payload_t            wdata_i,
  output payload_t            rdata_o
);

  // word array, contents undefined until written
  payload_t mem_q [num_words];
  payload_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // output register of the macro
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* src/llc_tag_pattern_gen.sv */
// --------------------------------------------------
// bist sequencer, three passes over every index
// ones written, read back and compared, then zeros
// compare results arrive one cycle after each read
// bist_res_o is valid together with done_o
// --------------------------------------------------
module llc_tag_pattern_gen (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    start_i,
  output logic                    ready_o,
  output llc_tag_pkg::index_t     index_o,
  output llc_tag_pkg::tag_entry_t pattern_o,
  output logic                    req_o,
  output logic                    we_o,
  input  llc_tag_pkg::way_ind_t   res_i,
  input  logic                    res_valid_i,
  output llc_tag_pkg::way_ind_t   bist_res_o,
  output logic                    done_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_wr_ones,
    st_rd_cmp,
    st_wr_zeros,
    st_done
  } state_e;

  state_e                state_d, state_q;
  llc_tag_pkg::index_t   index_d, index_q;
  llc_tag_pkg::way_ind_t fail_d, fail_q;
  logic                  last_index;

  assign last_index = (index_q == llc_tag_pkg::index_t'(llc_cfg_pkg::num_lines - 1));

  always_comb begin
    state_d = state_q;
    index_d = index_q;
    fail_d  = fail_q;
    // a 1 in res_i marks a mismatch in that way
    if (res_valid_i) begin
      fail_d = fail_q | res_i;
    end
    case (state_q)
      st_idle: begin
        if (start_i) begin
          state_d = st_wr_ones;
          index_d = '0;
          fail_d  = '0;
        end
      end
      st_wr_ones, st_rd_cmp, st_wr_zeros: begin
        index_d = last_index ? '0 : index_q + 1'b1;
        if (last_index) begin
          case (state_q)
            st_wr_ones: state_d = st_rd_cmp;
            st_rd_cmp:  state_d = st_wr_zeros;
            default:    state_d = st_done;
          endcase
        end
      end
      // last compare landed during the zero pass
      st_done: state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      index_q <= '0;
      fail_q  <= '0;
    end else begin
      state_q <= state_d;
      index_q <= index_d;
      fail_q  <= fail_d;
    end
  end

  assign ready_o    = (state_q == st_idle);
  assign index_o    = index_q;
  // ones also serve as the expected word of the read pass
  assign pattern_o  = (state_q == st_wr_zeros) ? '0 : '1;
  assign req_o      = (state_q == st_wr_ones) || (state_q == st_rd_cmp)
                   || (state_q == st_wr_zeros);
  assign we_o       = (state_q == st_wr_ones) || (state_q == st_wr_zeros);
  assign done_o     = (state_q == st_done);
  assign bist_res_o = fail_q;

endmodule

/* src/llc_evict_box.sv */
// --------------------------------------------------
// victim way choice for a lookup miss
// lowest invalid unlocked way first, else the lfsr
// picks from the unlocked ways
// lfsr steps once per req_i, so outputs hold between
// --------------------------------------------------
module llc_evict_box (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  llc_tag_pkg::way_ind_t valid_i,
  input  llc_tag_pkg::way_ind_t dirty_i,
  input  llc_tag_pkg::way_ind_t spm_lock_i,
  output llc_tag_pkg::way_ind_t way_ind_o,
  output logic                  evict_o
);

  logic [llc_cfg_pkg::lfsr_len-1:0] lfsr_q;
  llc_tag_pkg::way_ind_t            free;

  // fibonacci lfsr, shifts in the parity of the tapped bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= llc_cfg_pkg::lfsr_seed;
    end else if (req_i) begin
      lfsr_q <= {lfsr_q[llc_cfg_pkg::lfsr_len-2:0], ^(lfsr_q & llc_cfg_pkg::lfsr_taps)};
    end
  end

  // invalid lines that are not scratchpad
  assign free = ~valid_i & ~spm_lock_i;

  always_comb begin : proc_pick
    int unsigned start;
    int unsigned j;
    logic        found;
    way_ind_o = '0;
    evict_o   = 1'b0;
    found     = 1'b0;
    start     = lfsr_q[llc_cfg_pkg::way_idx_len-1:0];
    j         = 0;
    if (|free) begin
      // nothing to write back
      for (int unsigned i = 0; i < llc_cfg_pkg::num_ways; i++) begin
        if (free[i] && !found) begin
          way_ind_o[i] = 1'b1;
          found        = 1'b1;
        end
      end
    end else begin
      // walk up from the random start to the first unlocked way
      for (int unsigned k = 0; k < llc_cfg_pkg::num_ways; k++) begin
        j = (start + k) % llc_cfg_pkg::num_ways;
        if (!spm_lock_i[j] && !found) begin
          way_ind_o[j] = 1'b1;
          evict_o      = dirty_i[j] & valid_i[j];
          found        = 1'b1;
        end
      end
    end
  end

  // a fully locked set has nowhere to refill
  a_one_unlocked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |-> !(&spm_lock_i))
    else $error("victim requested with every way locked");

endmodule

/* src/llc_tag_store.sv */
// --------------------------------------------------
// tag store control over one memory per way
// req_i must hold while req_valid_i is high
// spm_lock_i and flushed_i must not change while a
// result waits; STORE and FLUSH take a one-hot way
// BIST always covers all ways
// --------------------------------------------------
module llc_tag_store (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  llc_tag_pkg::way_ind_t   flushed_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  llc_tag_pkg::tag_req_t   req_i,
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output llc_tag_pkg::tag_res_t   res_o,
  output logic                    gen_start_o,
  input  logic                    gen_ready_i,
  input  llc_tag_pkg::index_t     gen_index_i,
  input  llc_tag_pkg::tag_entry_t gen_pattern_i,
  input  logic                    gen_req_i,
  input  logic                    gen_we_i,
  input  logic                    gen_done_i,
  output llc_tag_pkg::way_ind_t   gen_res_o,
  output logic                    gen_res_valid_o,
  output logic                    evict_req_o,
  output llc_tag_pkg::way_ind_t   evict_valid_o,
  output llc_tag_pkg::way_ind_t   evict_dirty_o,
  input  llc_tag_pkg::way_ind_t   victim_i,
  input  logic                    evict_flag_i,
  output logic                    bist_valid_o
);

  // registers alongside the memories
  logic                    busy_d, busy_q;
  llc_tag_pkg::tag_req_e   mode_d, mode_q;
  llc_tag_pkg::way_ind_t   way_d, way_q;
  llc_tag_pkg::index_t     index_d, index_q;
  llc_tag_pkg::tag_entry_t entry_d, entry_q;
  logic                    bist_cmp_d, bist_cmp_q;

  // memory side
  llc_tag_pkg::way_ind_t   ram_req, ram_we;
  llc_tag_pkg::index_t     ram_index;
  llc_tag_pkg::tag_entry_t ram_wdata;
  llc_tag_pkg::tag_entry_t [llc_cfg_pkg::num_ways-1:0] ram_rdata;

  // per way status of the words just read
  llc_tag_pkg::way_ind_t   rd_valid, rd_dirty, hit, bist_fail;
  logic                    hit_any;
  logic                    accept;
  llc_tag_pkg::way_ind_t   res_way;
  llc_tag_pkg::tag_entry_t new_entry;

  // valid only matters for STORE, the other modes use the tag alone
  assign new_entry.valid = 1'b1;
  assign new_entry.dirty = req_i.dirty;
  assign new_entry.tag   = req_i.tag;

  assign hit_any = |hit;

  always_comb begin : proc_control
    busy_d       = busy_q;
    mode_d       = mode_q;
    way_d        = way_q;
    index_d      = index_q;
    entry_d      = entry_q;
    bist_cmp_d   = 1'b0;
    accept       = 1'b0;
    req_ready_o  = 1'b0;
    res_valid_o  = 1'b0;
    gen_start_o  = 1'b0;
    evict_req_o  = 1'b0;
    bist_valid_o = 1'b0;
    ram_req      = '0;
    ram_we       = '0;
    ram_index    = index_q;
    ram_wdata    = entry_q;

    if (busy_q) begin
      case (mode_q)
        llc_tag_pkg::BIST: begin
          ram_index  = gen_index_i;
          ram_req    = {llc_cfg_pkg::num_ways{gen_req_i}};
          ram_we     = {llc_cfg_pkg::num_ways{gen_we_i}};
          ram_wdata  = gen_pattern_i;
          // keep the expected word in step with the read data
          entry_d    = gen_pattern_i;
          bist_cmp_d = gen_req_i & ~gen_we_i;
          if (gen_done_i) begin
            busy_d       = 1'b0;
            bist_valid_o = 1'b1;
          end
        end
        // registered write, one cycle after acceptance
        llc_tag_pkg::STORE: begin
          ram_req = way_q;
          ram_we  = way_q;
          busy_d  = 1'b0;
        end
        llc_tag_pkg::FLUSH: begin
          res_valid_o = 1'b1;
          // clear the line once the result is taken
          if (res_ready_i) begin
            busy_d    = 1'b0;
            ram_req   = way_q;
            ram_we    = way_q;
            ram_wdata = '0;
          end
        end
        default: begin
          res_valid_o = 1'b1;
          if (res_ready_i) begin
            busy_d      = 1'b0;
            // victim used, step the lfsr
            evict_req_o = ~hit_any;
            // lookups and stores follow without a gap
            req_ready_o = (req_i.mode == llc_tag_pkg::LOOKUP)
                       || (req_i.mode == llc_tag_pkg::STORE);
            accept      = req_valid_i && req_ready_o;
          end
        end
      endcase
    end else begin
      gen_start_o = req_valid_i && (req_i.mode == llc_tag_pkg::BIST);
      req_ready_o = (req_i.mode != llc_tag_pkg::BIST) || gen_ready_i;
      accept      = req_valid_i && req_ready_o;
    end

    if (accept) begin
      busy_d      = 1'b1;
      mode_d      = req_i.mode;
      way_d       = req_i.way_ind;
      index_d     = req_i.index;
      entry_d     = new_entry;
      case (req_i.mode)
        llc_tag_pkg::FLUSH: begin
          ram_req   = req_i.way_ind;
          ram_index = req_i.index;
        end
        // read all ways for the victim, flushed ways cannot hit
        llc_tag_pkg::LOOKUP: begin
          way_d     = ~flushed_i;
          ram_req   = '1;
          ram_index = req_i.index;
        end
        default: begin
        end
      endcase
    end
  end

  for (genvar i = 0; i < llc_cfg_pkg::num_ways; i++) begin : gen_way
    llc_tag_ram #(
      .payload_t (llc_tag_pkg::tag_entry_t),
      .num_words (llc_cfg_pkg::num_lines)
    ) i_tag_ram (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (ram_req[i]),
      .we_i     (ram_we[i]),
      .addr_i   (ram_index),
      .wdata_i  (ram_wdata),
      .rdata_o  (ram_rdata[i])
    );

    assign rd_valid[i]  = ram_rdata[i].valid;
    assign rd_dirty[i]  = ram_rdata[i].dirty;
    assign hit[i]       = way_q[i] & rd_valid[i] & (ram_rdata[i].tag == entry_q.tag);
    // whole word, so stuck flag bits show up too
    assign bist_fail[i] = (ram_rdata[i] != entry_q);
  end

  assign evict_valid_o   = rd_valid;
  assign evict_dirty_o   = rd_dirty;
  assign gen_res_o       = bist_fail;
  assign gen_res_valid_o = bist_cmp_q;

  // result mux, flush way or hit way or victim
  always_comb begin : proc_result
    if (mode_q == llc_tag_pkg::FLUSH) begin
      res_way = way_q;
    end else begin
      res_way = hit_any ? hit : victim_i;
    end
    res_o.way_ind = res_way;
    res_o.hit     = (mode_q == llc_tag_pkg::LOOKUP) & hit_any;
    if (mode_q == llc_tag_pkg::FLUSH) begin
      res_o.evict = |(way_q & rd_valid & rd_dirty);
    end else begin
      res_o.evict = ~hit_any & evict_flag_i;
    end
    res_o.tag   = '0;
    res_o.dirty = 1'b0;
    for (int unsigned i = 0; i < llc_cfg_pkg::num_ways; i++) begin
      if (res_way[i]) begin
        res_o.tag   = ram_rdata[i].tag;
        res_o.dirty = ram_rdata[i].dirty;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      mode_q     <= llc_tag_pkg::BIST;
      way_q      <= '0;
      bist_cmp_q <= 1'b0;
    end else begin
      busy_q     <= busy_d;
      mode_q     <= mode_d;
      way_q      <= way_d;
      bist_cmp_q <= bist_cmp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    index_q <= index_d;
    entry_q <= entry_d;
  end

  // a tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mode_q != llc_tag_pkg::BIST) |-> $onehot0(hit))
    else $error("tag hits in more than one way");

  // a waiting result neither drops nor changes
  a_res_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
    else $error("result changed while stalled");

endmodule

/* src/llc_tag_top.sv */
// --------------------------------------------------
// tag side of the last level cache
// run BIST once after reset, it also clears all lines
// spm_lock_i needs at least one unlocked way
// --------------------------------------------------
module llc_tag_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  llc_tag_pkg::way_ind_t spm_lock_i,
  input  llc_tag_pkg::way_ind_t flushed_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  llc_tag_pkg::tag_req_t req_i,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output llc_tag_pkg::tag_res_t res_o,
  output llc_tag_pkg::way_ind_t bist_res_o,
  output logic                  bist_valid_o
);

  // store to pattern generator
  logic                    gen_start, gen_ready, gen_req, gen_we, gen_done;
  llc_tag_pkg::index_t     gen_index;
  llc_tag_pkg::tag_entry_t gen_pattern;
  llc_tag_pkg::way_ind_t   gen_res;
  logic                    gen_res_valid;

  // store to victim selector
  logic                    evict_req, evict_flag;
  llc_tag_pkg::way_ind_t   evict_valid, evict_dirty, victim;

  llc_tag_store i_store (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .flushed_i       (flushed_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_o           (res_o),
    .gen_start_o     (gen_start),
    .gen_ready_i     (gen_ready),
    .gen_index_i     (gen_index),
    .gen_pattern_i   (gen_pattern),
    .gen_req_i       (gen_req),
    .gen_we_i        (gen_we),
    .gen_done_i      (gen_done),
    .gen_res_o       (gen_res),
    .gen_res_valid_o (gen_res_valid),
    .evict_req_o     (evict_req),
    .evict_valid_o   (evict_valid),
    .evict_dirty_o   (evict_dirty),
    .victim_i        (victim),
    .evict_flag_i    (evict_flag),
    .bist_valid_o    (bist_valid_o)
  );

  llc_tag_pattern_gen i_pattern_gen (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (gen_start),
    .ready_o     (gen_ready),
    .index_o     (gen_index),
    .pattern_o   (gen_pattern),
    .req_o       (gen_req),
    .we_o        (gen_we),
    .res_i       (gen_res),
    .res_valid_i (gen_res_valid),
    .bist_res_o  (bist_res_o),
    .done_o      (gen_done)
  );

  llc_evict_box i_evict_box (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (evict_req),
    .valid_i    (evict_valid),
    .dirty_i    (evict_dirty),
    .spm_lock_i (spm_lock_i),
    .way_ind_o  (victim),
    .evict_o    (evict_flag)
  );

endmodule

/* test/tb_llc_tag_model.svh */
// --------------------------------------------------
// reference tag array for the tag store testbench
// model updates happen at request acceptance
// a miss with no free unlocked way leaves the victim
// open, the compare process resolves it
// --------------------------------------------------
`ifndef TB_LLC_TAG_MODEL_SVH
`define TB_LLC_TAG_MODEL_SVH

// expected result plus what is needed to judge a random victim
typedef struct packed {
  llc_tag_pkg::tag_res_t                                res;
  logic                                                 any_victim;
  llc_tag_pkg::way_ind_t                                lock;
  llc_tag_pkg::tag_entry_t [llc_cfg_pkg::num_ways-1:0]  set;
} exp_t;

llc_tag_pkg::tag_entry_t model_q [llc_cfg_pkg::num_ways][llc_cfg_pkg::num_lines];
int err_cnt = 0;

// lowest set bit of a way mask
function automatic int way_num(input llc_tag_pkg::way_ind_t m);
  int n;
  n = 0;
  for (int i = llc_cfg_pkg::num_ways - 1; i >= 0; i--) begin
    if (m[i]) begin
      n = i;
    end
  end
  return n;
endfunction

function automatic exp_t expect_result(input llc_tag_pkg::tag_req_t req,
                                       input llc_tag_pkg::way_ind_t lock,
                                       input llc_tag_pkg::way_ind_t flushed);
  exp_t                  e;
  llc_tag_pkg::way_ind_t hit;
  llc_tag_pkg::way_ind_t free;
  int                    w;
  e = '0;
  e.lock = lock;
  for (int i = 0; i < llc_cfg_pkg::num_ways; i++) begin
    e.set[i] = model_q[i][req.index];
    // flushed ways are read but never hit
    hit[i]  = !flushed[i] && e.set[i].valid && (e.set[i].tag == req.tag);
    free[i] = !e.set[i].valid && !lock[i];
  end
  if (req.mode == llc_tag_pkg::FLUSH) begin
    e.res.way_ind = req.way_ind;
  end else if (|hit) begin
    e.res.way_ind = hit;
    e.res.hit     = 1'b1;
  end else if (|free) begin
    e.res.way_ind = llc_tag_pkg::way_ind_t'(1) << way_num(free);
  end else begin
    e.any_victim = 1'b1;
    return e;
  end
  w = way_num(e.res.way_ind);
  e.res.tag   = e.set[w].tag;
  e.res.dirty = e.set[w].dirty;
  // hits and invalid victims need no write back
  e.res.evict = (req.mode == llc_tag_pkg::FLUSH) && e.set[w].valid && e.set[w].dirty;
  return e;
endfunction

task automatic apply_to_model(input llc_tag_pkg::tag_req_t req);
  case (req.mode)
    llc_tag_pkg::BIST: begin
      for (int w = 0; w < llc_cfg_pkg::num_ways; w++) begin
        for (int l = 0; l < llc_cfg_pkg::num_lines; l++) begin
          model_q[w][l] = '0;
        end
      end
    end
    llc_tag_pkg::STORE: model_q[way_num(req.way_ind)][req.index] = {1'b1, req.dirty, req.tag};
    llc_tag_pkg::FLUSH: model_q[way_num(req.way_ind)][req.index] = '0;
    default: begin
    end
  endcase
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first mismatch");
  end
endtask

`endif

/* test/tb_llc_tag_top.sv */
// --------------------------------------------------
// testbench for the tag store top level
// inputs change on the falling edge, outputs are
// sampled on the rising edge
// res_ready_i stalls at most max_stall cycles
// --------------------------------------------------
module tb_llc_tag_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 40;
  localparam int max_stall  = 3;
  localparam int rand_reqs  = 200;
  localparam int max_reqs   = rand_reqs + 40;
  localparam int bist_cycles = 3 * llc_cfg_pkg::num_lines + 16;
  localparam int margin     = 2;

  logic clk_i, arst_n_i, req_valid_i, req_ready_o, res_valid_o, res_ready_i, bist_valid_o;
  llc_tag_pkg::way_ind_t spm_lock_i, flushed_i, bist_res_o;
  llc_tag_pkg::tag_req_t req_i;
  llc_tag_pkg::tag_res_t res_o;

  integer seed = 32'h3125b768;
  int     stall_cnt = 0;
  logic   hold_q = 1'b0;
  llc_tag_pkg::tag_res_t held_res;

  `include "tb_llc_tag_model.svh"

  exp_t exp_q [$];

  llc_tag_top dut0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .spm_lock_i   (spm_lock_i),
    .flushed_i    (flushed_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_o        (res_o),
    .bist_res_o   (bist_res_o),
    .bist_valid_o (bist_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // bist, then every request with its longest stall
  initial begin
    #((bist_cycles + max_reqs * (max_stall + 3)) * margin * clk_period);
    $display("ERRORS FOUND");
    $fatal(1, "timeout, the run did not finish in the expected time");
  end

  function automatic llc_tag_pkg::tag_req_t make_req(input llc_tag_pkg::tag_req_e mode,
      input llc_tag_pkg::way_ind_t way, input int idx, input logic dirty, input int tag);
    llc_tag_pkg::tag_req_t r;
    r.mode    = mode;
    r.way_ind = way;
    r.index   = llc_tag_pkg::index_t'(idx);
    r.dirty   = dirty;
    r.tag     = llc_cfg_pkg::tag_len'(tag);
    return r;
  endfunction

  // small index and tag ranges so hits are common
  function automatic llc_tag_pkg::tag_req_t random_req();
    llc_tag_pkg::tag_req_t r;
    int unsigned           pick;
    pick = $unsigned($random(seed)) % 8;
    r = make_req(llc_tag_pkg::LOOKUP, '0, $unsigned($random(seed)) % 8, 1'($random(seed)),
                 $unsigned($random(seed)) % 16);
    r.way_ind = llc_tag_pkg::way_ind_t'(1 << ($unsigned($random(seed)) % llc_cfg_pkg::num_ways));
    if (pick >= 7) begin
      r.mode = llc_tag_pkg::FLUSH;
    end else if (pick >= 5) begin
      r.mode = llc_tag_pkg::STORE;
      // a tag already present is rewritten in place, never duplicated
      for (int w = 0; w < llc_cfg_pkg::num_ways; w++) begin
        if (model_q[w][r.index].valid && model_q[w][r.index].tag == r.tag) begin
          r.way_ind = llc_tag_pkg::way_ind_t'(1 << w);
        end
      end
    end
    return r;
  endfunction

  task automatic drive_ready();
    if (stall_cnt >= max_stall) begin
      res_ready_i = 1'b1;
    end else begin
      res_ready_i = ($random(seed) & 3) != 0;
    end
    stall_cnt = res_ready_i ? 0 : stall_cnt + 1;
  endtask

  task automatic send_req(input llc_tag_pkg::tag_req_t r);
    @(negedge clk_i);
    drive_ready();
    req_valid_i = 1'b1;
    req_i       = r;
    @(posedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
      drive_ready();
      @(posedge clk_i);
    end
    if (r.mode == llc_tag_pkg::LOOKUP || r.mode == llc_tag_pkg::FLUSH) begin
      exp_q.push_back(expect_result(r, spm_lock_i, flushed_i));
    end
    apply_to_model(r);
  endtask

  // lock and flushed masks only change with nothing outstanding
  task automatic drain();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    drive_ready();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      drive_ready();
    end
  endtask

  always @(posedge clk_i) begin : proc_compare
    exp_t e;
    int   w;
    if (hold_q) begin
      check_value("res_valid_o while stalled", res_valid_o, 1);
      check_value("res_o while stalled", res_o, held_res);
    end
    // a waiting result blocks new requests
    if (res_valid_o && !res_ready_i) begin
      check_value("req_ready_o while stalled", req_ready_o, 0);
    end
    hold_q   = res_valid_o && !res_ready_i;
    held_res = res_o;
    if (res_valid_o && res_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERRORS FOUND");
        $fatal(1, "a result arrived that no request asked for");
      end else begin
        e = exp_q.pop_front();
        if (e.any_victim) begin
          // lfsr victim, accept any single unlocked way
          check_value("res_o.way_ind one-hot", $onehot(res_o.way_ind), 1);
          check_value("res_o.way_ind locked bits", res_o.way_ind & e.lock, 0);
          w = way_num(res_o.way_ind);
          e.res.way_ind = res_o.way_ind;
          e.res.evict   = e.set[w].valid & e.set[w].dirty;
          e.res.tag     = e.set[w].tag;
          e.res.dirty   = e.set[w].dirty;
        end
        check_value("res_o.way_ind", res_o.way_ind, e.res.way_ind);
        check_value("res_o.hit", res_o.hit, e.res.hit);
        check_value("res_o.evict", res_o.evict, e.res.evict);
        check_value("res_o.tag", res_o.tag, e.res.tag);
        check_value("res_o.dirty", res_o.dirty, e.res.dirty);
      end
    end
  end

  initial begin : proc_stimulus
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b1;
    spm_lock_i  = '0;
    flushed_i   = '0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    check_value("res_valid_o after reset", res_valid_o, 0);
    check_value("bist_valid_o after reset", bist_valid_o, 0);
    check_value("req_ready_o after reset", req_ready_o, 1);

    send_req(make_req(llc_tag_pkg::BIST, '0, 0, 1'b0, 0));
    @(negedge clk_i);
    req_valid_i = 1'b0;
    do begin
      @(posedge clk_i);
      check_value("req_ready_o during BIST", req_ready_o, 0);
    end while (!bist_valid_o);
    check_value("bist_res_o", bist_res_o, 0);
    @(posedge clk_i);
    check_value("bist_valid_o after strobe", bist_valid_o, 0);

    // cleared array, misses go to way 0
    for (int i = 0; i < 4; i++) begin
      send_req(make_req(llc_tag_pkg::LOOKUP, '0, i * 9, 1'b0, 'h155));
    end
    send_req(make_req(llc_tag_pkg::STORE, 4'b0100, 5, 1'b1, 'h2a5));
    send_req(make_req(llc_tag_pkg::LOOKUP, '0, 5, 1'b0, 'h2a5));
    send_req(make_req(llc_tag_pkg::LOOKUP, '0, 5, 1'b0, 'h2a6));
    send_req(make_req(llc_tag_pkg::STORE, 4'b0001, 5, 1'b0, 'h011));
    send_req(make_req(llc_tag_pkg::STORE, 4'b0010, 5, 1'b1, 'h022));
    send_req(make_req(llc_tag_pkg::LOOKUP, '0, 5, 1'b0, 'h333));
    send_req(make_req(llc_tag_pkg::STORE, 4'b1000, 5, 1'b0, 'h044));
    drain();
    // full set with way 3 as scratchpad
    spm_lock_i = 4'b1000;
    for (int i = 0; i < 3; i++) begin
      send_req(make_req(llc_tag_pkg::LOOKUP, '0, 5, 1'b0, 'h300 + i));
    end
    drain();
    spm_lock_i = '0;
    send_req(make_req(llc_tag_pkg::FLUSH, 4'b0100, 5, 1'b0, 0));
    send_req(make_req(llc_tag_pkg::LOOKUP, '0, 5, 1'b0, 'h2a5));
    send_req(make_req(llc_tag_pkg::STORE, 4'b0010, 9, 1'b0, 'h0c3));
    drain();
    flushed_i = 4'b0010;
    send_req(make_req(llc_tag_pkg::LOOKUP, '0, 9, 1'b0, 'h0c3));
    drain();

    for (int c = 0; c < 4; c++) begin
      spm_lock_i = llc_tag_pkg::way_ind_t'($random(seed)) & 4'b0111;
      flushed_i  = llc_tag_pkg::way_ind_t'($random(seed));
      for (int n = 0; n < rand_reqs / 4; n++) begin
        send_req(random_req());
      end
      drain();
    end

    // no extra result may follow the last expected one
    repeat (4) begin
      @(posedge clk_i);
      check_value("res_valid_o when idle", res_valid_o, 0);
    end
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* llc_tag_top.f */
+incdir+test
src/llc_cfg_pkg.sv
src/llc_tag_pkg.sv
src/llc_tag_ram.sv
src/llc_tag_pattern_gen.sv
src/llc_evict_box.sv
src/llc_tag_store.sv
src/llc_tag_top.sv
test/tb_llc_tag_top.sv

/* Bender.yml */
package:
  name: llc_tag

sources:
  - files:
      - src/llc_cfg_pkg.sv
      - src/llc_tag_pkg.sv
      - src/llc_tag_ram.sv
      - src/llc_tag_pattern_gen.sv
      - src/llc_evict_box.sv
      - src/llc_tag_store.sv
      - src/llc_tag_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_llc_tag_top.sv
